/* rtl/daq_pkg.sv */
// --------------------------------------------------------------------------
// DAQ frame package
// Frame layout, halfword and sample types and the trigger source encoding
// shared by the acquisition frame builder
// --------------------------------------------------------------------------

package daq_pkg;

    // Frame geometry in 16-bit halfwords
    localparam int frame_words = 47;

    // Multiplexer IDs that open and close a fast sweep
    localparam int first_mux_id = 0;
    localparam int last_mux_id  = 31;

    // Halfword offsets inside one frame
    localparam int off_ts  = 0;
    localparam int off_pch = 4;
    localparam int off_tch = 20;
    localparam int off_pt  = 36;
    localparam int off_trg = 42;

    typedef logic [15:0] half_t;
    typedef logic [23:0] pt_t;

    // Trigger source select
    typedef enum logic [1:0] {
        src_mcu  = 2'b00,
        src_ext  = 2'b01,
        src_none = 2'b10,
        src_rtc  = 2'b11
    } trig_src_t;

endpackage

/* rtl/sample_capture.sv */
// --------------------------------------------------------------------------
// Sample capture
// Accepts the fast ADS868x stream and the slow PT100 stream, routes each
// multiplexer ID to its PCH or TCH slot, latches the RTC at sweep start
// and flags the start and end of every fast sweep
// --------------------------------------------------------------------------

module sample_capture
    import daq_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] s00_tdata,
    input  logic        s00_tvalid,
    output logic        s00_tready,
    input  logic [31:0] s01_tdata,
    input  logic        s01_tvalid,
    output logic        s01_tready,
    input  logic [31:0] rtc_second,
    input  logic [31:0] rtc_nanosecond,
    output logic [31:0] ts_s,
    output logic [31:0] ts_ns,
    output half_t       pch_data [16],
    output half_t       tch_data [16],
    output pt_t         pt_data [3],
    output logic        sweep_start,
    output logic        sweep_end
);

    logic [7:0] fast_id;
    logic [7:0] slow_ch;
    logic       fast_in_range;
    logic [3:0] chan_idx;
    logic       first_beat;
    logic       last_beat;

    assign fast_id       = s00_tdata[23:16];
    assign slow_ch       = s01_tdata[31:24];
    assign fast_in_range = (fast_id <= 8'(last_mux_id));

    // Board routing. ID[1] low selects channels 8..15, ID[0] high is PCH
    assign chan_idx   = {~fast_id[1], fast_id[4:2]};
    assign first_beat = s00_tvalid && (fast_id == 8'(first_mux_id));
    assign last_beat  = s00_tvalid && (fast_id == 8'(last_mux_id));

    // No back-pressure, ready simply follows reset
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s00_tready <= 1'b0;
            s01_tready <= 1'b0;
        end else begin
            s00_tready <= 1'b1;
            s01_tready <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Sample registers
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ts_s  <= '0;
            ts_ns <= '0;
            for (int i = 0; i < 16; i++) begin
                pch_data[i] <= '0;
                tch_data[i] <= '0;
            end
            for (int j = 0; j < 3; j++) begin
                pt_data[j] <= '0;
            end
        end else begin
            if (first_beat) begin
                ts_s  <= rtc_second;
                ts_ns <= rtc_nanosecond;
            end
            if (s00_tvalid && fast_in_range) begin
                if (fast_id[0]) begin
                    pch_data[chan_idx] <= s00_tdata[15:0];
                end else begin
                    tch_data[chan_idx] <= s00_tdata[15:0];
                end
            end
            // PT100 channels 0..2 only
            if (s01_tvalid && (slow_ch < 8'd3)) begin
                pt_data[slow_ch[1:0]] <= s01_tdata[23:0];
            end
        end
    end

    // Sweep markers lag the beat by one cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sweep_start <= 1'b0;
            sweep_end   <= 1'b0;
        end else begin
            sweep_start <= first_beat;
            sweep_end   <= last_beat;
        end
    end

endmodule

/* rtl/trigger_ctrl.sv */
// --------------------------------------------------------------------------
// Trigger control
// Synchronizes the MCU and external trigger pins, detects falling edges,
// matches the RTC against a programmed time and records whether the
// selected event fired before each sweep, with its timestamp
// --------------------------------------------------------------------------

module trigger_ctrl
    import daq_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        ext_trigger_pin,
    input  logic        mcu_trigger_pin,
    input  logic        ctrl_trigger_enable,
    input  trig_src_t   ctrl_trigger_source,
    input  logic [31:0] ctrl_trigger_second,
    input  logic [31:0] ctrl_trigger_nanosecond,
    input  logic [31:0] rtc_second,
    input  logic [31:0] rtc_nanosecond,
    input  logic        sweep_start,
    output logic        trg_flag,
    output logic [31:0] trg_s,
    output logic [31:0] trg_ns
);

    typedef enum logic [1:0] {
        st_reset,
        st_idle,
        st_armed,
        st_triggered
    } trg_state_t;

    trg_state_t           state;
    trg_state_t           state_next;
    logic [1:0]           pin_in;
    logic [SYNC_STAGES:0] pin_sync [2];
    logic [1:0]           pin_fall;
    logic                 rtc_match;
    logic                 trg_event;
    logic [31:0]          rtc_s_q;
    logic [31:0]          rtc_ns_q;

    // Index 0 is the MCU pin, index 1 the external pin
    assign pin_in = {ext_trigger_pin, mcu_trigger_pin};

    // Sync chain plus one extra flop for edge history
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < 2; i++) begin
                pin_sync[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                pin_sync[i] <= {pin_sync[i][SYNC_STAGES-1:0], pin_in[i]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pin_fall[i] = pin_sync[i][SYNC_STAGES] & ~pin_sync[i][SYNC_STAGES-1];
        end
    end

    assign rtc_match = (rtc_second == ctrl_trigger_second) &&
                       (rtc_nanosecond == ctrl_trigger_nanosecond);

    always_comb begin
        case (ctrl_trigger_source)
            src_mcu:  trg_event = pin_fall[0];
            src_ext:  trg_event = pin_fall[1];
            src_rtc:  trg_event = rtc_match;
            src_none: trg_event = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Trigger FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_reset:     state_next = st_idle;
            st_idle:      if (ctrl_trigger_enable) state_next = st_armed;
            st_armed:     if (!ctrl_trigger_enable) state_next = st_idle;
                          else if (trg_event) state_next = st_triggered;
            st_triggered: if (!ctrl_trigger_enable || sweep_start) state_next = st_idle;
        endcase
    end

    // sweep_start trails the ID-0 beat by one cycle, so take the RTC
    // from a one-cycle delayed copy to match the sample time
    always_ff @(posedge aclk) begin
        rtc_s_q  <= rtc_second;
        rtc_ns_q <= rtc_nanosecond;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            trg_flag <= 1'b0;
            trg_s    <= '0;
            trg_ns   <= '0;
        end else if (sweep_start) begin
            trg_flag <= (state == st_triggered);
            if (state == st_triggered) begin
                trg_s  <= rtc_s_q;
                trg_ns <= rtc_ns_q;
            end
        end
    end

endmodule

/* rtl/frame_writer.sv */
// --------------------------------------------------------------------------
// Frame writer
// Streams the 47-halfword acquisition frame into the block RAM after each
// sweep and stretches the completion interrupt
// --------------------------------------------------------------------------

module frame_writer
    import daq_pkg::*;
#(
    parameter int IRQ_CYCLES = 64
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        sweep_end,
    input  logic [31:0] ts_s,
    input  logic [31:0] ts_ns,
    input  half_t       pch_data [16],
    input  half_t       tch_data [16],
    input  pt_t         pt_data [3],
    input  logic        trg_flag,
    input  logic [31:0] trg_s,
    input  logic [31:0] trg_ns,
    output logic [11:0] bram_addr,
    output logic        bram_en,
    output logic [1:0]  bram_we,
    output half_t       bram_din,
    output logic        ts_irq
);

    localparam int irq_cnt_w = $clog2(IRQ_CYCLES + 1);

    logic [5:0]           word_cnt;
    logic                 busy;
    logic                 wr_now;
    logic [5:0]           word_idx;
    logic [5:0]           rel_idx;
    half_t                word_data;
    logic                 last_wr;
    logic [irq_cnt_w-1:0] irq_cnt;

    // Word 0 goes out straight from sweep_end, the rest from the counter
    assign wr_now   = sweep_end | busy;
    assign word_idx = sweep_end ? 6'd0 : word_cnt;
    assign last_wr  = bram_en && (bram_addr == 12'(frame_words - 1));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy     <= 1'b0;
            word_cnt <= '0;
        end else if (sweep_end) begin
            busy     <= 1'b1;
            word_cnt <= 6'd1;
        end else if (busy) begin
            if (word_cnt == 6'(frame_words - 1)) begin
                busy     <= 1'b0;
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 6'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Halfword select
    // ------------------------------------------------------------------------
    always_comb begin
        rel_idx   = '0;
        word_data = '0;
        if (word_idx < 6'(off_pch)) begin
            rel_idx = word_idx - 6'(off_ts);
            case (rel_idx[1:0])
                2'd0: word_data = ts_s[31:16];
                2'd1: word_data = ts_s[15:0];
                2'd2: word_data = ts_ns[31:16];
                2'd3: word_data = ts_ns[15:0];
            endcase
        end else if (word_idx < 6'(off_tch)) begin
            rel_idx   = word_idx - 6'(off_pch);
            word_data = pch_data[rel_idx[3:0]];
        end else if (word_idx < 6'(off_pt)) begin
            rel_idx   = word_idx - 6'(off_tch);
            word_data = tch_data[rel_idx[3:0]];
        end else if (word_idx < 6'(off_trg)) begin
            // PT100 split into upper byte then lower halfword
            rel_idx   = word_idx - 6'(off_pt);
            word_data = rel_idx[0] ? pt_data[rel_idx[2:1]][15:0]
                                   : {8'h00, pt_data[rel_idx[2:1]][23:16]};
        end else begin
            rel_idx = word_idx - 6'(off_trg);
            case (rel_idx[2:0])
                3'd0:    word_data = {15'd0, trg_flag};
                3'd1:    word_data = trg_s[31:16];
                3'd2:    word_data = trg_s[15:0];
                3'd3:    word_data = trg_ns[31:16];
                default: word_data = trg_ns[15:0];
            endcase
        end
    end

    // RAM port registers
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bram_en   <= 1'b0;
            bram_we   <= 2'b00;
            bram_addr <= '0;
        end else begin
            bram_en   <= wr_now;
            bram_we   <= {2{wr_now}};
            bram_addr <= wr_now ? 12'(word_idx) : 12'd0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_now) begin
            bram_din <= word_data;
        end
    end

    // Interrupt stretch, rises the cycle after the final write
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ts_irq  <= 1'b0;
            irq_cnt <= '0;
        end else if (last_wr) begin
            ts_irq  <= 1'b1;
            irq_cnt <= irq_cnt_w'(IRQ_CYCLES - 1);
        end else if (ts_irq) begin
            if (irq_cnt == '0) begin
                ts_irq <= 1'b0;
            end else begin
                irq_cnt <= irq_cnt - 1'b1;
            end
        end
    end

endmodule

/* rtl/daq_frame_top.sv */
// --------------------------------------------------------------------------
// DAQ frame builder top level
// Ties sample capture, trigger control and the frame writer together
// and exposes the block RAM port and the frame interrupt
// --------------------------------------------------------------------------

module daq_frame_top
    import daq_pkg::*;
#(
    parameter int SYNC_STAGES = 2,
    parameter int IRQ_CYCLES  = 64
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] s00_tdata,
    input  logic        s00_tvalid,
    output logic        s00_tready,
    input  logic [31:0] s01_tdata,
    input  logic        s01_tvalid,
    output logic        s01_tready,
    input  logic [31:0] rtc_second,
    input  logic [31:0] rtc_nanosecond,
    input  logic        ext_trigger_pin,
    input  logic        mcu_trigger_pin,
    input  logic        ctrl_trigger_enable,
    input  trig_src_t   ctrl_trigger_source,
    input  logic [31:0] ctrl_trigger_second,
    input  logic [31:0] ctrl_trigger_nanosecond,
    output logic        bram_clk,
    output logic        bram_rst,
    output logic [11:0] bram_addr,
    output logic        bram_en,
    output logic [1:0]  bram_we,
    output half_t       bram_din,
    // Read data is part of the RAM port but the frame is write only
    input  half_t       bram_dout,
    output logic        ts_irq
);

    logic [31:0] ts_s;
    logic [31:0] ts_ns;
    half_t       pch_data [16];
    half_t       tch_data [16];
    pt_t         pt_data [3];
    logic        sweep_start;
    logic        sweep_end;
    logic        trg_flag;
    logic [31:0] trg_s;
    logic [31:0] trg_ns;

    assign bram_clk = aclk;
    assign bram_rst = ~aresetn;

    sample_capture sample_capture_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s00_tdata     (s00_tdata),
        .s00_tvalid    (s00_tvalid),
        .s00_tready    (s00_tready),
        .s01_tdata     (s01_tdata),
        .s01_tvalid    (s01_tvalid),
        .s01_tready    (s01_tready),
        .rtc_second    (rtc_second),
        .rtc_nanosecond(rtc_nanosecond),
        .ts_s          (ts_s),
        .ts_ns         (ts_ns),
        .pch_data      (pch_data),
        .tch_data      (tch_data),
        .pt_data       (pt_data),
        .sweep_start   (sweep_start),
        .sweep_end     (sweep_end)
    );

    trigger_ctrl #(
        .SYNC_STAGES(SYNC_STAGES)
    ) trigger_ctrl_i (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .ext_trigger_pin        (ext_trigger_pin),
        .mcu_trigger_pin        (mcu_trigger_pin),
        .ctrl_trigger_enable    (ctrl_trigger_enable),
        .ctrl_trigger_source    (ctrl_trigger_source),
        .ctrl_trigger_second    (ctrl_trigger_second),
        .ctrl_trigger_nanosecond(ctrl_trigger_nanosecond),
        .rtc_second             (rtc_second),
        .rtc_nanosecond         (rtc_nanosecond),
        .sweep_start            (sweep_start),
        .trg_flag               (trg_flag),
        .trg_s                  (trg_s),
        .trg_ns                 (trg_ns)
    );

    frame_writer #(
        .IRQ_CYCLES(IRQ_CYCLES)
    ) frame_writer_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .sweep_end(sweep_end),
        .ts_s     (ts_s),
        .ts_ns    (ts_ns),
        .pch_data (pch_data),
        .tch_data (tch_data),
        .pt_data  (pt_data),
        .trg_flag (trg_flag),
        .trg_s    (trg_s),
        .trg_ns   (trg_ns),
        .bram_addr(bram_addr),
        .bram_en  (bram_en),
        .bram_we  (bram_we),
        .bram_din (bram_din),
        .ts_irq   (ts_irq)
    );

endmodule

/* sim/daq_frame_asserts.sv */
// --------------------------------------------------------------------------
// Frame writer assertions
// Checks the block RAM write port and the frame interrupt
// --------------------------------------------------------------------------

module daq_frame_asserts (
    input logic        aclk,
    input logic        aresetn,
    input logic        bram_en,
    input logic [1:0]  bram_we,
    input logic [11:0] bram_addr,
    input logic        ts_irq
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_fails = 0;

    // Byte enables are all ones exactly on enabled cycles
    we_follows_en: assert property (@(posedge aclk) disable iff (!aresetn)
        (bram_we == 2'b11) == bram_en)
    else begin
        $error("bram_we does not match bram_en");
        assert_fails++;
    end

    // Frame words go out at consecutive addresses
    addr_steps_by_one: assert property (@(posedge aclk) disable iff (!aresetn)
        bram_en ##1 bram_en |-> bram_addr == $past(bram_addr) + 12'd1)
    else begin
        $error("bram_addr did not advance by one");
        assert_fails++;
    end

    irq_after_write: assert property (@(posedge aclk) disable iff (!aresetn)
        !(ts_irq && bram_en))
    else begin
        $error("ts_irq high during a RAM write");
        assert_fails++;
    end

endmodule

bind frame_writer daq_frame_asserts frame_writer_asserts_i (.*);

/* sim/daq_frame_tb.sv */
// --------------------------------------------------------------------------
// DAQ frame builder testbench
// Random fast sweeps and PT100 beats, trigger scenarios on all sources,
// a block RAM model and a reference frame compared word by word
// --------------------------------------------------------------------------

module daq_frame_tb
    import daq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SYNC_STAGES      = 2;
    localparam int IRQ_CYCLES       = 64;
    localparam int num_sweeps       = 12;
    localparam int reset_cycles     = 10;
    // Slow beats, trigger setup, up to 64 sweep cycles and the irq window
    localparam int cycles_per_sweep = 300;
    localparam int timeout_cycles   = num_sweeps * cycles_per_sweep + reset_cycles + 20;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic [31:0] s00_tdata;
    logic        s00_tvalid;
    logic        s00_tready;
    logic [31:0] s01_tdata;
    logic        s01_tvalid;
    logic        s01_tready;
    logic [31:0] rtc_second;
    logic [31:0] rtc_nanosecond;
    logic        ext_trigger_pin;
    logic        mcu_trigger_pin;
    logic        ctrl_trigger_enable;
    trig_src_t   ctrl_trigger_source;
    logic [31:0] ctrl_trigger_second;
    logic [31:0] ctrl_trigger_nanosecond;
    logic        bram_clk;
    logic        bram_rst;
    logic [11:0] bram_addr;
    logic        bram_en;
    logic [1:0]  bram_we;
    half_t       bram_din;
    half_t       bram_dout;
    logic        ts_irq;

    int          seed;
    int          cycle_cnt = 0;
    half_t       ram_model [frame_words];

    // Reference model state
    half_t       exp_pch [16];
    half_t       exp_tch [16];
    pt_t         exp_pt [3];
    logic [31:0] exp_ts_s;
    logic [31:0] exp_ts_ns;
    logic [31:0] exp_trg_s;
    logic [31:0] exp_trg_ns;
    logic        exp_flag;
    half_t       exp_frame [frame_words];

    always #4 aclk = ~aclk;

    daq_frame_top #(
        .SYNC_STAGES(SYNC_STAGES),
        .IRQ_CYCLES (IRQ_CYCLES)
    ) daq_frame_top_i (.*);

    always @(posedge aclk) begin
        if (bram_en && (bram_we == 2'b11) && (bram_addr < frame_words)) begin
            ram_model[bram_addr] <= bram_din;
        end
    end

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("Timeout: run went past %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(posedge aclk) begin
        if (daq_frame_top_i.frame_writer_i.frame_writer_asserts_i.assert_fails != 0) begin
            $display("A bound assertion on the RAM port failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // RTC advances 8 ns per clock
    function automatic void rtc_step(inout logic [31:0] s, inout logic [31:0] ns);
        if (ns + 32'd8 >= 32'd1_000_000_000) begin
            ns = ns + 32'd8 - 32'd1_000_000_000;
            s  = s + 32'd1;
        end else begin
            ns = ns + 32'd8;
        end
    endfunction

    task automatic tick();
        @(posedge aclk);
        #1;
        rtc_step(rtc_second, rtc_nanosecond);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_slow_beats();
        logic [31:0] rnd;
        for (int i = 0; i < 6; i++) begin
            rnd        = $random(seed);
            s01_tdata  = {6'd0, rnd[25:24], rnd[23:0]};
            s01_tvalid = 1'b1;
            // Channel 3 is not a PT100 slot
            if (rnd[25:24] != 2'd3) begin
                exp_pt[rnd[25:24]] = rnd[23:0];
            end
            tick();
            s01_tvalid = 1'b0;
            if (rnd[31]) begin
                tick();
            end
        end
    endtask

    task automatic pin_edge(input bit ext);
        if (ext) begin
            ext_trigger_pin = 1'b0;
        end else begin
            mcu_trigger_pin = 1'b0;
        end
        repeat (4) tick();
        ext_trigger_pin = 1'b1;
        mcu_trigger_pin = 1'b1;
    endtask

    task automatic prepare_trigger(input int scenario, output logic fires);
        logic [31:0] t_s;
        logic [31:0] t_ns;
        ctrl_trigger_enable = 1'b0;
        repeat (2) tick();
        fires = 1'b0;
        case (scenario)
            0: begin
                // Disabled, an edge must be ignored
                ctrl_trigger_source = src_ext;
                pin_edge(1'b1);
            end
            1: begin
                ctrl_trigger_source = src_ext;
                ctrl_trigger_enable = 1'b1;
                tick();
                pin_edge(1'b1);
                fires = 1'b1;
            end
            2: begin
                ctrl_trigger_source = src_mcu;
                ctrl_trigger_enable = 1'b1;
                tick();
                pin_edge(1'b0);
                fires = 1'b1;
            end
            3: begin
                // Match time a few cycles ahead, well before the sweep
                t_s  = rtc_second;
                t_ns = rtc_nanosecond;
                repeat (6) rtc_step(t_s, t_ns);
                ctrl_trigger_second     = t_s;
                ctrl_trigger_nanosecond = t_ns;
                ctrl_trigger_source     = src_rtc;
                ctrl_trigger_enable     = 1'b1;
                fires = 1'b1;
            end
            4: begin
                ctrl_trigger_source = src_none;
                ctrl_trigger_enable = 1'b1;
                tick();
                pin_edge(1'b0);
                pin_edge(1'b1);
            end
            default: begin
                // Armed and triggered, then disabled before the sweep
                ctrl_trigger_source = src_ext;
                ctrl_trigger_enable = 1'b1;
                tick();
                pin_edge(1'b1);
                repeat (8) tick();
                ctrl_trigger_enable = 1'b0;
            end
        endcase
        repeat (12) tick();
    endtask

    // Ends one cycle after the ID-31 beat was driven
    task automatic send_sweep();
        logic [31:0] rnd;
        half_t       d;
        int          q;
        int          r;
        for (int n = 0; n < 32; n++) begin
            rnd        = $random(seed);
            d          = rnd[15:0];
            s00_tdata  = {rnd[31:24], 8'(n), d};
            s00_tvalid = 1'b1;
            if (n == first_mux_id) begin
                exp_ts_s  = rtc_second;
                exp_ts_ns = rtc_nanosecond;
            end
            q = n / 4;
            r = n % 4;
            case (r)
                0:       exp_tch[8 + q] = d;
                1:       exp_pch[8 + q] = d;
                2:       exp_tch[q] = d;
                default: exp_pch[q] = d;
            endcase
            tick();
            s00_tvalid = 1'b0;
            if ((n != last_mux_id) && rnd[16]) begin
                tick();
            end
        end
    endtask

    task automatic measure_irq();
        int latency;
        int high_cycles;
        latency = 1;
        while (ts_irq !== 1'b1) begin
            tick();
            latency++;
        end
        check_value("ts_irq latency", latency, 49);
        high_cycles = 0;
        while (ts_irq === 1'b1) begin
            high_cycles++;
            tick();
        end
        check_value("ts_irq width", high_cycles, IRQ_CYCLES);
    endtask

    task automatic check_frame();
        exp_frame[off_ts]     = exp_ts_s[31:16];
        exp_frame[off_ts + 1] = exp_ts_s[15:0];
        exp_frame[off_ts + 2] = exp_ts_ns[31:16];
        exp_frame[off_ts + 3] = exp_ts_ns[15:0];
        for (int i = 0; i < 16; i++) begin
            exp_frame[off_pch + i] = exp_pch[i];
            exp_frame[off_tch + i] = exp_tch[i];
        end
        for (int i = 0; i < 3; i++) begin
            exp_frame[off_pt + 2 * i]     = {8'h00, exp_pt[i][23:16]};
            exp_frame[off_pt + 2 * i + 1] = exp_pt[i][15:0];
        end
        exp_frame[off_trg]     = {15'd0, exp_flag};
        exp_frame[off_trg + 1] = exp_trg_s[31:16];
        exp_frame[off_trg + 2] = exp_trg_s[15:0];
        exp_frame[off_trg + 3] = exp_trg_ns[31:16];
        exp_frame[off_trg + 4] = exp_trg_ns[15:0];
        for (int w = 0; w < frame_words; w++) begin
            check_value($sformatf("ram_model[%0d]", w), ram_model[w], exp_frame[w]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic fires;
        seed                    = 71295;
        aresetn                 = 1'b0;
        s00_tdata               = '0;
        s00_tvalid              = 1'b0;
        s01_tdata               = '0;
        s01_tvalid              = 1'b0;
        rtc_second              = 32'h6543_2100;
        rtc_nanosecond          = 32'd999_999_200;
        ext_trigger_pin         = 1'b1;
        mcu_trigger_pin         = 1'b1;
        ctrl_trigger_enable     = 1'b0;
        ctrl_trigger_source     = src_none;
        ctrl_trigger_second     = '0;
        ctrl_trigger_nanosecond = '0;
        bram_dout               = '0;
        for (int i = 0; i < 16; i++) begin
            exp_pch[i] = '0;
            exp_tch[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            exp_pt[i] = '0;
        end
        exp_trg_s  = '0;
        exp_trg_ns = '0;
        exp_flag   = 1'b0;

        repeat (reset_cycles / 2) tick();
        check_value("s00_tready", s00_tready, 1'b0);
        check_value("s01_tready", s01_tready, 1'b0);
        check_value("bram_rst", bram_rst, 1'b1);
        // RAM clock follows aclk in both phases
        check_value("bram_clk", bram_clk, 1'b1);
        @(negedge aclk);
        #1;
        check_value("bram_clk", bram_clk, 1'b0);
        repeat (reset_cycles - reset_cycles / 2) tick();
        aresetn = 1'b1;
        tick();
        check_value("s00_tready", s00_tready, 1'b1);
        check_value("s01_tready", s01_tready, 1'b1);
        check_value("bram_rst", bram_rst, 1'b0);

        for (int s = 0; s < num_sweeps; s++) begin
            send_slow_beats();
            prepare_trigger(s % 6, fires);
            for (int w = 0; w < frame_words; w++) begin
                ram_model[w] = 'x;
            end
            send_sweep();
            // Trigger time follows the sample time only on a fired trigger
            exp_flag = fires;
            if (fires) begin
                exp_trg_s  = exp_ts_s;
                exp_trg_ns = exp_ts_ns;
            end
            measure_irq();
            check_frame();
        end

        if (daq_frame_top_i.frame_writer_i.frame_writer_asserts_i.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Assertion failures were reported on the RAM port");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* files.f */
rtl/daq_pkg.sv
rtl/sample_capture.sv
rtl/trigger_ctrl.sv
rtl/frame_writer.sv
rtl/daq_frame_top.sv
sim/daq_frame_asserts.sv
sim/daq_frame_tb.sv

/* Bender.yml */
package:
  name: daq_frame

sources:
  # Synthesizable design
  - target: any(rtl, simulation)
    files:
      - rtl/daq_pkg.sv
      - rtl/sample_capture.sv
      - rtl/trigger_ctrl.sv
      - rtl/frame_writer.sv
      - rtl/daq_frame_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/daq_frame_asserts.sv
      - sim/daq_frame_tb.sv
